// ==== crypto_control.f ====
+incdir+test
rtl/crypto_pkg.sv
rtl/duplex_if.sv
rtl/range_addresser.sv
rtl/duplex_core.sv
rtl/crypto_sequencer.sv
rtl/crypto_control.sv
test/tb_crypto_control.sv

// ==== Bender.yml ====
package:
  name: crypto_control

sources:
  - rtl/crypto_pkg.sv
  - rtl/duplex_if.sv
  - rtl/range_addresser.sv
  - rtl/duplex_core.sv
  - rtl/crypto_sequencer.sv
  - rtl/crypto_control.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_crypto_control.sv

// ==== test/tb_crypto_model.svh ====
`ifndef TB_CRYPTO_MODEL_SVH
`define TB_CRYPTO_MODEL_SVH

// galois lfsr, x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_state = 32'hcd6b_0af5;

// duplex state of the reference cipher
crypto_pkg::word_t ref_s;

// word-addressed memory and its expected image
crypto_pkg::word_t mem [0:32767];
crypto_pkg::word_t exp_mem [0:32767];

function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out)
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    return out;
endfunction

function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] acc;
    acc = '0;
    for (int i = 0; i < n; i++)
        acc = {acc[62:0], lfsr_bit()};
    return acc;
endfunction

// rotate left by three, then add the constant
function automatic crypto_pkg::word_t mix_word(input crypto_pkg::word_t x);
    return {x[12:0], x[15:13]} + 16'h9e37;
endfunction

function automatic void cipher_init(input logic [63:0] k);
    ref_s = k[15:0] ^ k[31:16] ^ k[47:32] ^ k[63:48];
endfunction

function automatic void absorb_word(input crypto_pkg::word_t a);
    ref_s = mix_word(ref_s ^ a);
endfunction

function automatic crypto_pkg::word_t encrypt_word(input crypto_pkg::word_t p);
    crypto_pkg::word_t c;
    c = p ^ ref_s;
    ref_s = mix_word(ref_s ^ p);
    return c;
endfunction

function automatic crypto_pkg::word_t decrypt_word(input crypto_pkg::word_t c);
    crypto_pkg::word_t p;
    p = c ^ ref_s;
    ref_s = mix_word(ref_s ^ p);
    return p;
endfunction

function automatic crypto_pkg::word_t squeeze_word();
    crypto_pkg::word_t out;
    out = ref_s;
    ref_s = mix_word(ref_s);
    return out;
endfunction

// odd multiplier keeps every word index distinct
function automatic crypto_pkg::word_t fill_word(input int idx);
    return crypto_pkg::word_t'(idx * 27459) ^ 16'ha5c3;
endfunction

task automatic mem_fill();
    for (int i = 0; i < 32768; i++)
    begin
        mem[i]     = fill_word(i);
        exp_mem[i] = mem[i];
    end
endtask

task automatic mem_put(input crypto_pkg::word_t addr, input crypto_pkg::word_t data);
    mem[addr[15:1]]     = data;
    exp_mem[addr[15:1]] = data;
endtask

task automatic expect_word(input crypto_pkg::word_t addr, input crypto_pkg::word_t data);
    exp_mem[addr[15:1]] = data;
endtask

function automatic crypto_pkg::word_t mem_peek(input crypto_pkg::word_t addr);
    return mem[addr[15:1]];
endfunction

function automatic crypto_pkg::word_t expected_at(input crypto_pkg::word_t addr);
    return exp_mem[addr[15:1]];
endfunction

task automatic compare_memory(input string what);
    for (int i = 0; i < 32768; i++)
    begin
        assert (mem[i] === exp_mem[i])
            else check_fail($sformatf("%s: word at %h is %h, expected %h",
                                      what, i * 2, mem[i], exp_mem[i]));
    end
endtask

`endif

// ==== test/tb_crypto_control.sv ====
`timescale 1ns/1ps

module tb_crypto_control;

    logic                            clk;
    logic                            reset;
    logic                            start_valid;
    logic                            start_ready;
    crypto_pkg::cmd_e                cmd;
    logic [crypto_pkg::KEY_BITS-1:0] key;
    crypto_pkg::word_t               ad_start;
    crypto_pkg::word_t               ad_end;
    crypto_pkg::word_t               body_start;
    crypto_pkg::word_t               body_end;
    crypto_pkg::word_t               out_start;
    crypto_pkg::word_t               tag_addr;
    logic                            mem_en;
    logic                            mem_we;
    crypto_pkg::word_t               mem_addr;
    crypto_pkg::word_t               mem_wdata;
    crypto_pkg::word_t               mem_rdata = '0;
    logic                            result_valid;
    logic                            result_ok;

    int   accept_count = 0;
    int   issued_count = 0;
    logic busy;
    logic prev_result;

    logic [63:0]       wrap_key;
    crypto_pkg::word_t ad_words [0:2];
    crypto_pkg::word_t pt_words [0:4];
    crypto_pkg::word_t ct_words [0:4];

    `include "tb_crypto_model.svh"

    crypto_control i_dut (
        .clk          (clk),
        .reset        (reset),
        .start_valid  (start_valid),
        .start_ready  (start_ready),
        .cmd          (cmd),
        .key          (key),
        .ad_start     (ad_start),
        .ad_end       (ad_end),
        .body_start   (body_start),
        .body_end     (body_end),
        .out_start    (out_start),
        .tag_addr     (tag_addr),
        .mem_en       (mem_en),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .result_valid (result_valid),
        .result_ok    (result_ok)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // read data one cycle after the request
    always @(posedge clk)
    begin
        if (mem_en)
        begin
            if (mem_we)
                mem[mem_addr[15:1]] = mem_wdata;
            else
                mem_rdata <= mem[mem_addr[15:1]];
        end
    end

    task automatic stop_with_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_fail(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        stop_with_failure();
    endtask

    // handshake and result pulse sampled mid-cycle
    always @(negedge clk)
    begin
        if (reset)
        begin
            busy        = 1'b0;
            prev_result = 1'b0;
        end
        else
        begin
            assert (!(result_valid && prev_result))
                else check_fail("result_valid high for more than one cycle");
            if (busy)
            begin
                assert (!start_ready)
                    else check_fail("start_ready high while a command is busy");
            end
            if (prev_result)
            begin
                assert (start_ready)
                    else check_fail("start_ready not high after result_valid");
            end
            if (result_valid)
            begin
                assert (busy)
                    else check_fail("result_valid without an accepted command");
            end
            if (start_valid && start_ready)
                accept_count++;
            if (result_valid)
                busy = 1'b0;
            else if (start_valid && start_ready)
                busy = 1'b1;
            prev_result = result_valid;
        end
    end

    task automatic wait_start_ready(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!start_ready)
        begin
            cycles++;
            if (cycles > 1000)
                abort_run($sformatf("timeout waiting for start_ready before %s", name));
            else
                @(negedge clk);
        end
    endtask

    task automatic wait_result(input string name, output logic ok);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!result_valid)
        begin
            cycles++;
            if (cycles > 2000)
                abort_run($sformatf("timeout waiting for result_valid of %s", name));
            else
                @(negedge clk);
        end
        ok = result_ok;
    endtask

    task automatic run_command(
        input  crypto_pkg::cmd_e  op,
        input  logic [63:0]       k,
        input  crypto_pkg::word_t as,
        input  crypto_pkg::word_t ae,
        input  crypto_pkg::word_t bs,
        input  crypto_pkg::word_t be,
        input  crypto_pkg::word_t os,
        input  crypto_pkg::word_t ta,
        input  string             name,
        output logic              ok
    );
        @(posedge clk);
        #2;
        cmd         = op;
        key         = k;
        ad_start    = as;
        ad_end      = ae;
        body_start  = bs;
        body_end    = be;
        out_start   = os;
        tag_addr    = ta;
        start_valid = 1'b1;
        wait_start_ready(name);
        @(posedge clk);
        // start_valid stays high while busy and is ignored
        repeat (2) @(posedge clk);
        #2;
        start_valid = 1'b0;
        wait_result(name, ok);
        @(posedge clk);
        issued_count++;
        assert (accept_count == issued_count)
            else check_fail($sformatf("%s: %0d commands accepted, expected %0d",
                                      name, accept_count, issued_count));
    endtask

    // model of an unwrap of the stored ciphertext
    task automatic predict_unwrap(input crypto_pkg::word_t out_base, output logic ok_exp);
        ok_exp = 1'b1;
        cipher_init(wrap_key);
        for (int i = 0; i < 3; i++)
            absorb_word(ad_words[i]);
        for (int i = 0; i < 5; i++)
            expect_word(out_base + crypto_pkg::word_t'(2 * i), decrypt_word(ct_words[i]));
        for (int i = 0; i < crypto_pkg::TAG_WORDS; i++)
        begin
            if (squeeze_word() !== expected_at(16'h4000 + crypto_pkg::word_t'(2 * i)))
                ok_exp = 1'b0;
        end
    endtask

    task automatic check_plaintext(input crypto_pkg::word_t out_base, input string name);
        for (int i = 0; i < 5; i++)
        begin
            assert (mem_peek(out_base + crypto_pkg::word_t'(2 * i)) === pt_words[i])
                else check_fail($sformatf("%s: plaintext word %0d not restored", name, i));
        end
    endtask

    initial
    begin
        logic        ok;
        logic        exp_ok;
        logic [63:0] empty_key;

        reset       = 1'b1;
        start_valid = 1'b0;
        cmd         = crypto_pkg::CMD_WRAP;
        key         = '0;
        ad_start    = '0;
        ad_end      = '0;
        body_start  = '0;
        body_end    = '0;
        out_start   = '0;
        tag_addr    = '0;
        mem_fill();
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        @(negedge clk);
        assert (!result_valid && !mem_en && !mem_we && start_ready
                && !i_dut.duplex_bus.req_valid)
            else check_fail("outputs not idle after reset");

        // wrap with 3 ad words and 5 body words
        wrap_key = rand_bits(64);
        for (int i = 0; i < 3; i++)
        begin
            ad_words[i] = crypto_pkg::word_t'(rand_bits(16));
            mem_put(16'h1000 + crypto_pkg::word_t'(2 * i), ad_words[i]);
        end
        for (int i = 0; i < 5; i++)
        begin
            pt_words[i] = crypto_pkg::word_t'(rand_bits(16));
            mem_put(16'h2000 + crypto_pkg::word_t'(2 * i), pt_words[i]);
        end
        cipher_init(wrap_key);
        for (int i = 0; i < 3; i++)
            absorb_word(ad_words[i]);
        for (int i = 0; i < 5; i++)
        begin
            ct_words[i] = encrypt_word(pt_words[i]);
            expect_word(16'h3000 + crypto_pkg::word_t'(2 * i), ct_words[i]);
        end
        for (int i = 0; i < crypto_pkg::TAG_WORDS; i++)
            expect_word(16'h4000 + crypto_pkg::word_t'(2 * i), squeeze_word());
        run_command(crypto_pkg::CMD_WRAP, wrap_key, 16'h1000, 16'h1006, 16'h2000,
                    16'h200a, 16'h3000, 16'h4000, "wrap", ok);
        assert (ok === 1'b1)
            else check_fail("wrap result_ok is not 1");
        compare_memory("wrap");

        // unwrap of the stored ciphertext
        predict_unwrap(16'h5000, exp_ok);
        run_command(crypto_pkg::CMD_UNWRAP, wrap_key, 16'h1000, 16'h1006, 16'h3000,
                    16'h300a, 16'h5000, 16'h4000, "unwrap", ok);
        assert (ok === exp_ok)
            else check_fail($sformatf("unwrap result_ok is %b, expected %b", ok, exp_ok));
        check_plaintext(16'h5000, "unwrap");
        compare_memory("unwrap");

        // one flipped tag bit
        mem_put(16'h4004, expected_at(16'h4004) ^ 16'h0010);
        predict_unwrap(16'h6000, exp_ok);
        run_command(crypto_pkg::CMD_UNWRAP, wrap_key, 16'h1000, 16'h1006, 16'h3000,
                    16'h300a, 16'h6000, 16'h4000, "bad tag unwrap", ok);
        assert (ok === exp_ok)
            else check_fail($sformatf("bad tag unwrap result_ok is %b, expected %b",
                                      ok, exp_ok));
        check_plaintext(16'h6000, "bad tag unwrap");
        compare_memory("bad tag unwrap");

        // clear of 6 words
        for (int i = 0; i < 6; i++)
        begin
            mem_put(16'h7000 + crypto_pkg::word_t'(2 * i), crypto_pkg::word_t'(rand_bits(16)));
            expect_word(16'h7000 + crypto_pkg::word_t'(2 * i), 16'h0000);
        end
        run_command(crypto_pkg::CMD_CLEAR, wrap_key, 16'h0000, 16'h0000, 16'h7000,
                    16'h700c, 16'h0000, 16'h0000, "clear", ok);
        assert (ok === 1'b1)
            else check_fail("clear result_ok is not 1");
        // neighbors at word index 0x37ff and 0x3806
        assert (mem_peek(16'h6ffe) === fill_word('h37ff))
            else check_fail("clear changed the word before the range");
        assert (mem_peek(16'h700c) === fill_word('h3806))
            else check_fail("clear changed the word after the range");
        compare_memory("clear");

        // empty ad and body ranges leave only the tag
        empty_key = rand_bits(64);
        cipher_init(empty_key);
        for (int i = 0; i < crypto_pkg::TAG_WORDS; i++)
            expect_word(16'h4800 + crypto_pkg::word_t'(2 * i), squeeze_word());
        run_command(crypto_pkg::CMD_WRAP, empty_key, 16'h1000, 16'h1000, 16'h2000,
                    16'h2000, 16'h3800, 16'h4800, "empty wrap", ok);
        assert (ok === 1'b1)
            else check_fail("empty wrap result_ok is not 1");
        compare_memory("empty wrap");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== rtl/crypto_control.sv ====
`timescale 1ns/1ps

module crypto_control (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            start_valid,
    output logic                            start_ready,
    input  crypto_pkg::cmd_e                cmd,
    input  logic [crypto_pkg::KEY_BITS-1:0] key,
    input  crypto_pkg::word_t               ad_start,
    input  crypto_pkg::word_t               ad_end,
    input  crypto_pkg::word_t               body_start,
    input  crypto_pkg::word_t               body_end,
    input  crypto_pkg::word_t               out_start,
    input  crypto_pkg::word_t               tag_addr,
    output logic                            mem_en,
    output logic                            mem_we,
    output crypto_pkg::word_t               mem_addr,
    output crypto_pkg::word_t               mem_wdata,
    input  crypto_pkg::word_t               mem_rdata,
    output logic                            result_valid,
    output logic                            result_ok
);

    logic              rd_init;
    crypto_pkg::word_t rd_base;
    crypto_pkg::word_t rd_limit;
    logic              rd_inc;
    logic              wr_init;
    crypto_pkg::word_t wr_base;
    logic              wr_inc;
    logic              sel_wr;
    logic              rd_done;

    duplex_if duplex_bus ();

    crypto_sequencer i_seq (
        .clk          (clk),
        .reset        (reset),
        .start_valid  (start_valid),
        .start_ready  (start_ready),
        .cmd          (cmd),
        .ad_start     (ad_start),
        .ad_end       (ad_end),
        .body_start   (body_start),
        .body_end     (body_end),
        .out_start    (out_start),
        .tag_addr     (tag_addr),
        .mem_rdata    (mem_rdata),
        .mem_en       (mem_en),
        .mem_we       (mem_we),
        .mem_wdata    (mem_wdata),
        .result_valid (result_valid),
        .result_ok    (result_ok),
        .duplex       (duplex_bus.seq),
        .rd_init      (rd_init),
        .rd_base      (rd_base),
        .rd_limit     (rd_limit),
        .rd_inc       (rd_inc),
        .wr_init      (wr_init),
        .wr_base      (wr_base),
        .wr_inc       (wr_inc),
        .sel_wr       (sel_wr),
        .rd_done      (rd_done)
    );

    range_addresser i_addr (
        .clk      (clk),
        .reset    (reset),
        .rd_init  (rd_init),
        .rd_base  (rd_base),
        .rd_limit (rd_limit),
        .rd_inc   (rd_inc),
        .wr_init  (wr_init),
        .wr_base  (wr_base),
        .wr_inc   (wr_inc),
        .sel_wr   (sel_wr),
        .mem_addr (mem_addr),
        .rd_done  (rd_done)
    );

    duplex_core i_core (
        .clk    (clk),
        .reset  (reset),
        .key    (key),
        .duplex (duplex_bus.core)
    );

endmodule

// ==== rtl/crypto_sequencer.sv ====
`timescale 1ns/1ps

module crypto_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              start_valid,
    output logic              start_ready,
    input  crypto_pkg::cmd_e  cmd,
    input  crypto_pkg::word_t ad_start,
    input  crypto_pkg::word_t ad_end,
    input  crypto_pkg::word_t body_start,
    input  crypto_pkg::word_t body_end,
    input  crypto_pkg::word_t out_start,
    input  crypto_pkg::word_t tag_addr,
    input  crypto_pkg::word_t mem_rdata,
    output logic              mem_en,
    output logic              mem_we,
    output crypto_pkg::word_t mem_wdata,
    output logic              result_valid,
    output logic              result_ok,
    duplex_if.seq             duplex,
    output logic              rd_init,
    output crypto_pkg::word_t rd_base,
    output crypto_pkg::word_t rd_limit,
    output logic              rd_inc,
    output logic              wr_init,
    output crypto_pkg::word_t wr_base,
    output logic              wr_inc,
    output logic              sel_wr,
    input  logic              rd_done
);

    crypto_pkg::seq_state_e                   state;
    crypto_pkg::seq_state_e                   next_state;
    crypto_pkg::cmd_e                         cmd_q;
    logic                                     mismatch_q;
    logic [$clog2(crypto_pkg::TAG_WORDS)-1:0] tag_cnt;
    logic                                     unwrap;
    logic                                     tag_last;
    logic                                     tag_step;

    assign unwrap       = cmd_q == crypto_pkg::CMD_UNWRAP;
    assign tag_last     = int'(tag_cnt) == crypto_pkg::TAG_WORDS - 1;
    assign tag_step     = (state == crypto_pkg::S_TAG_RSP) && duplex.rsp_valid;
    assign start_ready  = state == crypto_pkg::S_IDLE;
    assign result_valid = state == crypto_pkg::S_RESULT;
    assign result_ok    = !mismatch_q;

    always_comb
    begin
        next_state       = state;
        mem_en           = 1'b0;
        mem_we           = 1'b0;
        mem_wdata        = '0;
        rd_init          = 1'b0;
        rd_base          = '0;
        rd_limit         = '0;
        rd_inc           = 1'b0;
        wr_init          = 1'b0;
        wr_base          = '0;
        wr_inc           = 1'b0;
        sel_wr           = 1'b0;
        duplex.req_valid = 1'b0;
        duplex.req_op    = crypto_pkg::OP_INIT;
        duplex.req_data  = '0;

        case (state)
            crypto_pkg::S_IDLE:
                if (start_valid)
                    next_state = (cmd == crypto_pkg::CMD_CLEAR) ? crypto_pkg::S_CLR_INIT
                                                                : crypto_pkg::S_INIT;
            // key init overlaps loading the AD range
            crypto_pkg::S_INIT:
            begin
                duplex.req_valid = 1'b1;
                rd_init          = 1'b1;
                rd_base          = ad_start;
                rd_limit         = ad_end;
                if (duplex.req_ready)
                    next_state = crypto_pkg::S_AD_RD;
            end
            crypto_pkg::S_AD_RD:
                if (rd_done)
                    next_state = crypto_pkg::S_BODY_INIT;
                else
                begin
                    mem_en     = 1'b1;
                    rd_inc     = 1'b1;
                    next_state = crypto_pkg::S_AD_REQ;
                end
            crypto_pkg::S_AD_REQ:
            begin
                duplex.req_valid = 1'b1;
                duplex.req_op    = crypto_pkg::OP_ABSORB;
                duplex.req_data  = mem_rdata;
                if (duplex.req_ready)
                    next_state = crypto_pkg::S_AD_RD;
            end
            crypto_pkg::S_BODY_INIT:
            begin
                rd_init    = 1'b1;
                rd_base    = body_start;
                rd_limit   = body_end;
                wr_init    = 1'b1;
                wr_base    = out_start;
                next_state = crypto_pkg::S_BODY_RD;
            end
            crypto_pkg::S_BODY_RD:
                if (rd_done)
                    next_state = crypto_pkg::S_TAG_INIT;
                else
                begin
                    mem_en     = 1'b1;
                    rd_inc     = 1'b1;
                    next_state = crypto_pkg::S_BODY_REQ;
                end
            crypto_pkg::S_BODY_REQ:
            begin
                duplex.req_valid = 1'b1;
                duplex.req_op    = unwrap ? crypto_pkg::OP_DECRYPT : crypto_pkg::OP_ENCRYPT;
                duplex.req_data  = mem_rdata;
                if (duplex.req_ready)
                    next_state = crypto_pkg::S_BODY_WR;
            end
            crypto_pkg::S_BODY_WR:
                if (duplex.rsp_valid)
                begin
                    mem_en     = 1'b1;
                    mem_we     = 1'b1;
                    sel_wr     = 1'b1;
                    mem_wdata  = duplex.rsp_data;
                    wr_inc     = 1'b1;
                    next_state = crypto_pkg::S_BODY_RD;
                end
            crypto_pkg::S_TAG_INIT:
            begin
                rd_init    = 1'b1;
                rd_base    = tag_addr;
                rd_limit   = tag_addr + crypto_pkg::word_t'(crypto_pkg::TAG_WORDS
                                                            * crypto_pkg::ADDR_STEP);
                wr_init    = 1'b1;
                wr_base    = tag_addr;
                next_state = crypto_pkg::S_TAG_REQ;
            end
            // unwrap fetches the stored tag word alongside the squeeze
            crypto_pkg::S_TAG_REQ:
            begin
                duplex.req_valid = 1'b1;
                duplex.req_op    = crypto_pkg::OP_SQUEEZE;
                if (duplex.req_ready)
                begin
                    mem_en     = unwrap;
                    rd_inc     = unwrap;
                    next_state = crypto_pkg::S_TAG_RSP;
                end
            end
            crypto_pkg::S_TAG_RSP:
                if (duplex.rsp_valid)
                begin
                    mem_en     = !unwrap;
                    mem_we     = !unwrap;
                    sel_wr     = 1'b1;
                    mem_wdata  = duplex.rsp_data;
                    wr_inc     = !unwrap;
                    next_state = tag_last ? crypto_pkg::S_RESULT : crypto_pkg::S_TAG_REQ;
                end
            crypto_pkg::S_CLR_INIT:
            begin
                rd_init    = 1'b1;
                rd_base    = body_start;
                rd_limit   = body_end;
                next_state = crypto_pkg::S_CLR_LOOP;
            end
            crypto_pkg::S_CLR_LOOP:
                if (rd_done)
                    next_state = crypto_pkg::S_RESULT;
                else
                begin
                    mem_en = 1'b1;
                    mem_we = 1'b1;
                    rd_inc = 1'b1;
                end
            default:
                next_state = crypto_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= crypto_pkg::S_IDLE;
            cmd_q      <= crypto_pkg::CMD_WRAP;
            mismatch_q <= 1'b0;
            tag_cnt    <= '0;
        end
        else
        begin
            state <= next_state;
            if (start_valid && start_ready)
            begin
                cmd_q      <= cmd;
                mismatch_q <= 1'b0;
            end
            else if (tag_step && unwrap && (duplex.rsp_data != mem_rdata))
                mismatch_q <= 1'b1;
            if (state == crypto_pkg::S_TAG_INIT)
                tag_cnt <= '0;
            else if (tag_step)
                tag_cnt <= tag_cnt + 1'b1;
        end
    end

    a_we_needs_en: assert property (
        @(posedge clk) disable iff (reset)
        mem_we |-> mem_en
    );

endmodule

// ==== rtl/duplex_core.sv ====
`timescale 1ns/1ps

module duplex_core (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [crypto_pkg::KEY_BITS-1:0] key,
    duplex_if.core                          duplex
);

    crypto_pkg::word_t s;
    crypto_pkg::word_t mix_in;
    crypto_pkg::word_t out_word;
    crypto_pkg::word_t s_next;
    crypto_pkg::word_t rsp_data_q;
    logic              ready_q;
    logic              rsp_valid_q;
    logic              accept;

    function automatic crypto_pkg::word_t mix(input crypto_pkg::word_t x);
        crypto_pkg::word_t rot;
        rot = (x << crypto_pkg::MIX_ROT) | (x >> (16 - crypto_pkg::MIX_ROT));
        return rot + crypto_pkg::MIX_CONST;
    endfunction

    function automatic crypto_pkg::word_t key_fold(
        input logic [crypto_pkg::KEY_BITS-1:0] k
    );
        crypto_pkg::word_t acc;
        acc = '0;
        for (int i = 0; i < crypto_pkg::KEY_WORDS; i++)
            acc = acc ^ k[i*16 +: 16];
        return acc;
    endfunction

    assign accept = duplex.req_valid && ready_q;

    always_comb
    begin
        mix_in   = s;
        out_word = s;
        case (duplex.req_op)
            crypto_pkg::OP_ABSORB:
                mix_in = s ^ duplex.req_data;
            crypto_pkg::OP_ENCRYPT:
            begin
                out_word = duplex.req_data ^ s;
                mix_in   = s ^ duplex.req_data;
            end
            crypto_pkg::OP_DECRYPT:
            begin
                out_word = duplex.req_data ^ s;
                // s xor plaintext is the ciphertext itself
                mix_in   = duplex.req_data;
            end
            default:
                mix_in = s;
        endcase
    end

    assign s_next = (duplex.req_op == crypto_pkg::OP_INIT) ? key_fold(key) : mix(mix_in);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ready_q     <= 1'b1;
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            ready_q     <= !accept;
            rsp_valid_q <= accept;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            s          <= s_next;
            rsp_data_q <= out_word;
        end
    end

    assign duplex.req_ready = ready_q;
    assign duplex.rsp_valid = rsp_valid_q;
    assign duplex.rsp_data  = rsp_data_q;

    // a stalled request must not change under the core
    a_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        (duplex.req_valid && !duplex.req_ready) |=>
            (duplex.req_valid && $stable(duplex.req_op) && $stable(duplex.req_data))
    );

endmodule

// ==== rtl/range_addresser.sv ====
`timescale 1ns/1ps

module range_addresser (
    input  logic              clk,
    input  logic              reset,
    input  logic              rd_init,
    input  crypto_pkg::word_t rd_base,
    input  crypto_pkg::word_t rd_limit,
    input  logic              rd_inc,
    input  logic              wr_init,
    input  crypto_pkg::word_t wr_base,
    input  logic              wr_inc,
    input  logic              sel_wr,
    output crypto_pkg::word_t mem_addr,
    output logic              rd_done
);

    crypto_pkg::word_t rd_cnt;
    crypto_pkg::word_t rd_lim;
    crypto_pkg::word_t wr_cnt;

    // read side walks the source range up to its limit
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_cnt <= '0;
            rd_lim <= '0;
        end
        else if (rd_init)
        begin
            rd_cnt <= rd_base;
            rd_lim <= rd_limit;
        end
        else if (rd_inc)
            rd_cnt <= rd_cnt + crypto_pkg::word_t'(crypto_pkg::ADDR_STEP);
    end

    // output side for ciphertext, plaintext and tag writes
    always_ff @(posedge clk)
    begin
        if (reset)
            wr_cnt <= '0;
        else if (wr_init)
            wr_cnt <= wr_base;
        else if (wr_inc)
            wr_cnt <= wr_cnt + crypto_pkg::word_t'(crypto_pkg::ADDR_STEP);
    end

    assign rd_done  = rd_cnt >= rd_lim;
    assign mem_addr = sel_wr ? wr_cnt : rd_cnt;

    // the sequencer never steps past the end of a range
    a_no_inc_when_done: assert property (
        @(posedge clk) disable iff (reset)
        !(rd_inc && rd_done)
    );

endmodule

// ==== rtl/duplex_if.sv ====
`timescale 1ns/1ps

interface duplex_if;

    // request side, held until req_ready
    logic                   req_valid;
    logic                   req_ready;
    crypto_pkg::duplex_op_e req_op;
    crypto_pkg::word_t      req_data;

    // one-cycle response, no back-pressure
    logic                   rsp_valid;
    crypto_pkg::word_t      rsp_data;

    modport seq (
        output req_valid,
        output req_op,
        output req_data,
        input  req_ready,
        input  rsp_valid,
        input  rsp_data
    );

    modport core (
        input  req_valid,
        input  req_op,
        input  req_data,
        output req_ready,
        output rsp_valid,
        output rsp_data
    );

endinterface

// ==== rtl/crypto_pkg.sv ====
package crypto_pkg;

    typedef logic [15:0] word_t;

    localparam int KEY_BITS  = 64;
    localparam int KEY_WORDS = 4;
    localparam int TAG_WORDS = 4;
    localparam int ADDR_STEP = 2;

    // mixing step of the duplex core
    localparam word_t MIX_CONST = 16'h9e37;
    localparam int    MIX_ROT   = 3;

    typedef enum logic [1:0] {
        CMD_WRAP,
        CMD_UNWRAP,
        CMD_CLEAR
    } cmd_e;

    typedef enum logic [2:0] {
        OP_INIT,
        OP_ABSORB,
        OP_ENCRYPT,
        OP_DECRYPT,
        OP_SQUEEZE
    } duplex_op_e;

    typedef enum logic [3:0] {
        S_IDLE,
        S_INIT,
        S_AD_RD,
        S_AD_REQ,
        S_BODY_INIT,
        S_BODY_RD,
        S_BODY_REQ,
        S_BODY_WR,
        S_TAG_INIT,
        S_TAG_REQ,
        S_TAG_RSP,
        S_CLR_INIT,
        S_CLR_LOOP,
        S_RESULT
    } seq_state_e;

endpackage
